// File: Makefile
SRCS = nx4_cmd_config.svh nx4_cmd_pkg.sv cmd_parser.sv addr_gen.sv reg_file.sv \
	pixel_write.sv tx_sequencer.sv nx4_cmd_top.sv nx4_cmd_assert.sv tb_nx4_cmd.sv

.PHONY: run clean

obj_dir/Vtb_nx4_cmd: $(SRCS) nx4_cmd.f
	verilator --binary --assert --top-module tb_nx4_cmd -f nx4_cmd.f

run: obj_dir/Vtb_nx4_cmd
	./obj_dir/Vtb_nx4_cmd | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: addr_gen.sv
`timescale 1ns/1ps

module addr_gen (
	input logic CLK_40,
	input logic reset,
	input nx4_cmd_pkg::cmd_ctl_t ctl,
	input logic ctl_valid,
	input nx4_cmd_pkg::byte_t autoinc_len,
	input nx4_cmd_pkg::byte_t autoinc_modulo,
	output nx4_cmd_pkg::cmd_addr_t addr
);
	import nx4_cmd_pkg::*;

	byte_t mod_cnt;	// payload bytes since the last jump or load
	logic jump;
	cmd_addr_t modulo_ext;

	// end of an autoinc run replaces the +1 with the signed modulo
	assign jump = (autoinc_len != 8'd0) && (mod_cnt == autoinc_len);
	assign modulo_ext = {{8{autoinc_modulo[7]}}, autoinc_modulo};

	always_ff @(posedge CLK_40 or posedge reset) begin
		if (reset) begin
			addr <= '0;
			mod_cnt <= 8'd1;
		end else if (ctl_valid) begin
			if (ctl.addr_lo_load) begin
				addr <= {8'h00, ctl.data};
				mod_cnt <= 8'd1;
			end else if (ctl.addr_hi_load) begin
				addr <= {ctl.data, addr[7:0]};	// keep low byte, no increment
				mod_cnt <= 8'd1;
			end else if (ctl.payload) begin
				if (jump) begin
					addr <= addr + modulo_ext;
					mod_cnt <= 8'd1;
				end else begin
					addr <= addr + 16'd1;	// post-increment
					mod_cnt <= mod_cnt + 8'd1;
				end
			end
		end
	end

endmodule

// File: cmd_parser.sv
`timescale 1ns/1ps
`include "nx4_cmd_config.svh"

module cmd_parser (
	input logic CLK_40,
	input logic reset,
	input nx4_cmd_pkg::rx_byte_t rx,
	input logic rx_valid,
	input nx4_cmd_pkg::unit_id_t unit_id,
	output nx4_cmd_pkg::cmd_ctl_t ctl,
	output logic ctl_valid
);
	import nx4_cmd_pkg::*;

	parse_state_e state, state_nx;
	byte_t id_byte;	// first byte of the current message
	cmd_mode_t id_mode;
	unit_id_t id_unit;
	logic unit_ok;
	cmd_ctl_t ctl_nx;
	logic emit;

	assign id_mode = id_byte[`NX4_CMD_MODE_LSB +: 3];
	assign id_unit = id_byte[`NX4_CMD_UNIT_LSB +: 4];
	assign unit_ok = (id_unit == unit_id) || (id_unit == `NX4_UNIT_ID_BROADCAST);

	always_comb begin
		state_nx = state;
		emit = 1'b0;
		ctl_nx = '0;
		ctl_nx.mode = id_mode;
		ctl_nx.is_write = id_byte[`NX4_CMD_WRITE_BIT];
		ctl_nx.data = rx.data;
		if (rx_valid) begin
			if (rx.start) begin
				state_nx = PS_GOT_ID;	// start always restarts, even mid message
			end else begin
				case (state)
					PS_GOT_ID: begin
						if (unit_ok) begin
							emit = 1'b1;
							ctl_nx.addr_lo_load = 1'b1;
							// only fb mode carries a second address byte
							state_nx = (id_mode == `NX4_MODE_FB) ? PS_GOT_ADDR : PS_PAYLOAD;
						end else begin
							state_nx = PS_IDLE;	// someone else's message
						end
					end
					PS_GOT_ADDR: begin
						emit = 1'b1;
						ctl_nx.addr_hi_load = 1'b1;
						state_nx = PS_PAYLOAD;
					end
					PS_PAYLOAD: begin
						emit = 1'b1;
						ctl_nx.payload = 1'b1;
					end
					default: ;	// idle until next start byte
				endcase
			end
		end
	end

	always_ff @(posedge CLK_40 or posedge reset) begin
		if (reset) begin
			state <= PS_IDLE;
			ctl_valid <= 1'b0;
		end else begin
			state <= state_nx;
			ctl_valid <= emit;	// one cycle after the rx byte
		end
	end

	always_ff @(posedge CLK_40) begin
		if (rx_valid && rx.start)
			id_byte <= rx.data;
		ctl <= ctl_nx;
	end

endmodule

// File: nx4_cmd.f
+incdir+.
nx4_cmd_pkg.sv
cmd_parser.sv
addr_gen.sv
reg_file.sv
pixel_write.sv
tx_sequencer.sv
nx4_cmd_top.sv
nx4_cmd_assert.sv
tb_nx4_cmd.sv

// File: nx4_cmd_assert.sv
`timescale 1ns/1ps

module nx4_cmd_assert (
	input logic CLK_40,
	input logic reset,
	input nx4_cmd_pkg::byte_t tx_data,
	input logic tx_valid,
	input logic tx_ready,
	input nx4_cmd_pkg::fb_wr_t fb_wr,
	input nx4_cmd_pkg::lut_wr_t lut_wr
);
	logic fb_any;	// either framebuffer written

	assign fb_any = fb_wr.we0 || fb_wr.we1;

	a_tx_hold: assert property (@(posedge CLK_40) disable iff (reset)
		tx_valid && !tx_ready |=> $stable(tx_data))
		else $error("tx_data changed while waiting for tx_ready");

	a_reset_quiet: assert property (@(posedge CLK_40)
		reset && $past(reset) |-> !tx_valid && !fb_any && !lut_wr.we)
		else $error("tx_valid or a write enable high during reset");

	a_one_port: assert property (@(posedge CLK_40) disable iff (reset) !(fb_any && lut_wr.we))
		else $error("framebuffer and gamma written in the same cycle");

	//////////////////////////////////////////////////////////////////////
	// single-cycle enables
	//////////////////////////////////////////////////////////////////////
	a_we0_pulse: assert property (@(posedge CLK_40) disable iff (reset)
		fb_wr.we0 |=> !fb_wr.we0) else $error("fb_wr.we0 high two cycles");
	a_we1_pulse: assert property (@(posedge CLK_40) disable iff (reset)
		fb_wr.we1 |=> !fb_wr.we1) else $error("fb_wr.we1 high two cycles");
	a_lut_pulse: assert property (@(posedge CLK_40) disable iff (reset)
		lut_wr.we |=> !lut_wr.we) else $error("lut_wr.we high two cycles");

endmodule

bind nx4_cmd_top nx4_cmd_assert i_assert (
	.CLK_40(CLK_40), .reset(reset), .tx_data(tx_data), .tx_valid(tx_valid),
	.tx_ready(tx_ready), .fb_wr(fb_wr), .lut_wr(lut_wr)
);

// File: nx4_cmd_config.svh
`ifndef NX4_CMD_CONFIG_SVH
`define NX4_CMD_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////
`define NX4_FB_ADDR_BITS	12	// framebuffer address bus
`define NX4_LUT_DATA_BITS	12	// intensity lookup entry
`define NX4_REG_COUNT		16

//////////////////////////////////////////////////////////////////////
// register map
//////////////////////////////////////////////////////////////////////
`define NX4_REG_SYSCTL			4'h0
`define NX4_SYSCTL_BIT_FB0_WRITE	0	// pixel writes go to fb0
`define NX4_SYSCTL_BIT_FB1_WRITE	1	// pixel writes go to fb1
`define NX4_REG_UNIT_ID			4'h1	// low nibble is our unit id
`define NX4_REG_AUTOINC_LEN		4'h8	// 0 = plain post-increment
`define NX4_REG_AUTOINC_MODULO	4'h9	// signed jump added at end of run

`define NX4_SYSCTL_RESET	8'h01	// only fb0 written after reset
`define NX4_UNIT_ID_BROADCAST	4'hF

// id byte layout
`define NX4_CMD_MODE_LSB	0	// mode in [2:0]
`define NX4_CMD_WRITE_BIT	3
`define NX4_CMD_UNIT_LSB	4	// unit id in [7:4]

`define NX4_MODE_REG	3'd0
`define NX4_MODE_FB		3'd1
`define NX4_MODE_GAMMA	3'd4

// sent once on tx after reset, first char in the top byte
`define NX4_BOOT_LEN	16
`define NX4_BOOT_TEXT	"\nOpenNX4 V0.0.1\n"

`endif

// File: nx4_cmd_pkg.sv
`include "nx4_cmd_config.svh"

package nx4_cmd_pkg;

	//////////////////////////////////////////////////////////////////////
	// basic vectors
	//////////////////////////////////////////////////////////////////////
	typedef logic [7:0] byte_t;
	typedef logic [15:0] cmd_addr_t;	// shared by reg, fb and gamma modes
	typedef logic [`NX4_FB_ADDR_BITS-1:0] fb_addr_t;
	typedef logic [7:0] lut_addr_t;	// 256 gamma entries
	typedef logic [`NX4_LUT_DATA_BITS-1:0] lut_data_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [3:0] unit_id_t;
	typedef logic [2:0] cmd_mode_t;
	typedef byte_t [`NX4_REG_COUNT-1:0] reg_bank_t;	// whole bank as one packed vector

	typedef enum logic [1:0] {
		PS_IDLE,	// waiting for a start byte
		PS_GOT_ID,	// id latched, next byte is addr low
		PS_GOT_ADDR,	// fb mode only, next byte is addr high
		PS_PAYLOAD
	} parse_state_e;

	//////////////////////////////////////////////////////////////////////
	// bundles between blocks
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		byte_t data;
		logic start;	// first byte of a message
	} rx_byte_t;

	// one per accepted byte, qualified by ctl_valid
	typedef struct packed {
		cmd_mode_t mode;
		logic is_write;
		logic addr_lo_load;
		logic addr_hi_load;
		logic payload;
		byte_t data;
	} cmd_ctl_t;

	typedef struct packed {
		logic we0;
		logic we1;
		fb_addr_t addr;
		byte_t data;
	} fb_wr_t;

	typedef struct packed {
		logic we;
		lut_addr_t addr;
		lut_data_t data;
	} lut_wr_t;

endpackage

// File: nx4_cmd_top.sv
`timescale 1ns/1ps

module nx4_cmd_top (
	input logic CLK_40,
	input logic reset,
	input nx4_cmd_pkg::rx_byte_t rx,
	input logic rx_valid,
	input nx4_cmd_pkg::byte_t status,
	input logic tx_ready,
	output nx4_cmd_pkg::byte_t tx_data,
	output logic tx_valid,
	output nx4_cmd_pkg::fb_wr_t fb_wr,
	output nx4_cmd_pkg::lut_wr_t lut_wr,
	output nx4_cmd_pkg::reg_bank_t regs
);
	import nx4_cmd_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// internal nets
	//////////////////////////////////////////////////////////////////////
	cmd_ctl_t ctl;	// per-byte command from the parser
	logic ctl_valid;
	cmd_addr_t addr;
	unit_id_t unit_id;
	byte_t autoinc_len, autoinc_modulo;
	logic [1:0] fb_sel;
	byte_t reply;
	logic reply_valid;

	cmd_parser u_parser (
		.CLK_40(CLK_40), .reset(reset), .rx(rx), .rx_valid(rx_valid),
		.unit_id(unit_id), .ctl(ctl), .ctl_valid(ctl_valid)
	);

	addr_gen u_addr (
		.CLK_40(CLK_40), .reset(reset), .ctl(ctl), .ctl_valid(ctl_valid),
		.autoinc_len(autoinc_len), .autoinc_modulo(autoinc_modulo), .addr(addr)
	);

	reg_file u_regs (
		.CLK_40(CLK_40), .reset(reset), .ctl(ctl), .ctl_valid(ctl_valid),
		.addr(addr), .status(status), .regs(regs), .unit_id(unit_id),
		.autoinc_len(autoinc_len), .autoinc_modulo(autoinc_modulo),
		.fb_sel(fb_sel), .reply(reply), .reply_valid(reply_valid)
	);

	pixel_write u_pix (
		.CLK_40(CLK_40), .reset(reset), .ctl(ctl), .ctl_valid(ctl_valid),
		.addr(addr), .fb_sel(fb_sel), .fb_wr(fb_wr), .lut_wr(lut_wr)
	);

	tx_sequencer u_tx (
		.CLK_40(CLK_40), .reset(reset), .reply(reply), .reply_valid(reply_valid),
		.rx_valid(rx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .tx_valid(tx_valid)
	);

endmodule

// File: pixel_write.sv
`timescale 1ns/1ps
`include "nx4_cmd_config.svh"

module pixel_write (
	input logic CLK_40,
	input logic reset,
	input nx4_cmd_pkg::cmd_ctl_t ctl,
	input logic ctl_valid,
	input nx4_cmd_pkg::cmd_addr_t addr,
	input logic [1:0] fb_sel,
	output nx4_cmd_pkg::fb_wr_t fb_wr,
	output nx4_cmd_pkg::lut_wr_t lut_wr
);
	import nx4_cmd_pkg::*;

	logic wr_pay, fb_hit, gamma_hit;
	logic [1:0] fb_we;	// {we1, we0}
	logic lut_we;
	fb_addr_t fb_addr;
	byte_t fb_data;
	lut_addr_t lut_addr;
	lut_data_t lut_data;
	logic [3:0] msb_latch;	// top nibble of the gamma entry, sent first

	assign wr_pay = ctl_valid && ctl.payload && ctl.is_write;	// reads are ignored here
	assign fb_hit = wr_pay && (ctl.mode == `NX4_MODE_FB);
	assign gamma_hit = wr_pay && (ctl.mode == `NX4_MODE_GAMMA);

	always_ff @(posedge CLK_40 or posedge reset) begin
		if (reset) begin
			fb_we <= 2'b00;
			lut_we <= 1'b0;
		end else begin
			fb_we <= fb_hit ? fb_sel : 2'b00;
			lut_we <= gamma_hit && addr[0];	// odd byte completes the pair
		end
	end

	always_ff @(posedge CLK_40) begin
		fb_addr <= addr[`NX4_FB_ADDR_BITS-1:0];	// pre-increment address
		fb_data <= ctl.data;
		lut_addr <= addr[8:1];	// two bytes per entry
		lut_data <= {msb_latch, ctl.data};
		if (gamma_hit && !addr[0])
			msb_latch <= ctl.data[3:0];
	end

	assign fb_wr = '{we0: fb_we[0], we1: fb_we[1], addr: fb_addr, data: fb_data};
	assign lut_wr = '{we: lut_we, addr: lut_addr, data: lut_data};

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "nx4_cmd_config.svh"

module reg_file (
	input logic CLK_40,
	input logic reset,
	input nx4_cmd_pkg::cmd_ctl_t ctl,
	input logic ctl_valid,
	input nx4_cmd_pkg::cmd_addr_t addr,
	input nx4_cmd_pkg::byte_t status,
	output nx4_cmd_pkg::reg_bank_t regs,
	output nx4_cmd_pkg::unit_id_t unit_id,
	output nx4_cmd_pkg::byte_t autoinc_len,
	output nx4_cmd_pkg::byte_t autoinc_modulo,
	output logic [1:0] fb_sel,
	output nx4_cmd_pkg::byte_t reply,
	output logic reply_valid
);
	import nx4_cmd_pkg::*;

	reg_idx_t idx;
	logic reg_hit;	// register-mode data byte

	assign idx = addr[3:0];	// upper address bits ignored in reg mode
	assign reg_hit = ctl_valid && ctl.payload && (ctl.mode == `NX4_MODE_REG);

	// fields other blocks need
	assign unit_id = regs[`NX4_REG_UNIT_ID][3:0];
	assign autoinc_len = regs[`NX4_REG_AUTOINC_LEN];
	assign autoinc_modulo = regs[`NX4_REG_AUTOINC_MODULO];
	assign fb_sel = {regs[`NX4_REG_SYSCTL][`NX4_SYSCTL_BIT_FB1_WRITE],
		regs[`NX4_REG_SYSCTL][`NX4_SYSCTL_BIT_FB0_WRITE]};

	always_ff @(posedge CLK_40 or posedge reset) begin
		if (reset) begin
			regs <= '0;
			regs[`NX4_REG_SYSCTL] <= `NX4_SYSCTL_RESET;
			reply_valid <= 1'b0;
		end else begin
			reply_valid <= reg_hit;	// every reg byte gets exactly one reply
			if (reg_hit && ctl.is_write)
				regs[idx] <= ctl.data;
		end
	end

	// write echoes status pins, read returns the old value
	always_ff @(posedge CLK_40) begin
		if (reg_hit)
			reply <= ctl.is_write ? status : regs[idx];
	end

endmodule

// File: tb_nx4_cmd.sv
`timescale 1ns/1ps
`include "nx4_cmd_config.svh"

module tb_nx4_cmd;
	import nx4_cmd_pkg::*;

	localparam int N_RAND = 150;	// random messages after the directed ones
	localparam int N_MSGS = N_RAND + 16;

	logic CLK_40, reset;
	rx_byte_t rx;
	logic rx_valid, tx_ready, tx_valid;
	byte_t status, tx_data;
	fb_wr_t fb_wr;
	lut_wr_t lut_wr;
	reg_bank_t regs;

	//////////////////////////////////////////////////////////////////////
	// reference model state
	//////////////////////////////////////////////////////////////////////
	parse_state_e m_state;
	byte_t m_id;	// id byte of the current message
	byte_t m_cnt;	// position inside the autoinc run
	cmd_addr_t m_addr;
	logic [3:0] m_latch;	// gamma high nibble
	reg_bank_t m_regs;
	byte_t txq [$];	// expected tx bytes, in order
	byte_t pay_q [$];	// payload bytes of the next message
	fb_wr_t cur_fb, s1_fb, s2_fb;	// expected ports, delayed two cycles
	lut_wr_t cur_lut, s1_lut, s2_lut;
	reg_bank_t s1_regs, s2_regs;
	int errors, checks, ready_hold;
	string boot;

	nx4_cmd_top i_dut (
		.CLK_40(CLK_40), .reset(reset), .rx(rx), .rx_valid(rx_valid), .status(status),
		.tx_ready(tx_ready), .tx_data(tx_data), .tx_valid(tx_valid), .fb_wr(fb_wr),
		.lut_wr(lut_wr), .regs(regs)
	);

	initial begin
		CLK_40 = 1'b0;
		forever #4 CLK_40 = ~CLK_40;	// 8 ns period
	end

	initial begin
		repeat (N_MSGS * 64 + 2000) @(posedge CLK_40);
		$display("watchdog expired before the message sequence finished");
		$display("tests failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// one accepted rx byte through the parser, address and register rules
	task automatic model_byte(input logic start, input byte_t data);
		cmd_mode_t mode;
		logic wr;
		byte_t len, modulo;
		reg_idx_t idx;
		mode = m_id[`NX4_CMD_MODE_LSB +: 3];
		wr = m_id[`NX4_CMD_WRITE_BIT];
		len = m_regs[`NX4_REG_AUTOINC_LEN];	// values before this byte's write
		modulo = m_regs[`NX4_REG_AUTOINC_MODULO];
		idx = m_addr[3:0];
		if (start) begin
			m_id = data;
			m_state = PS_GOT_ID;
		end else begin
			case (m_state)
				PS_GOT_ID: begin
					if (m_id[7:4] == m_regs[`NX4_REG_UNIT_ID][3:0] ||
						m_id[7:4] == `NX4_UNIT_ID_BROADCAST) begin
						m_addr = {8'h00, data};
						m_cnt = 8'd1;
						m_state = (mode == `NX4_MODE_FB) ? PS_GOT_ADDR : PS_PAYLOAD;
					end else begin
						m_state = PS_IDLE;	// foreign unit
					end
				end
				PS_GOT_ADDR: begin
					m_addr[15:8] = data;
					m_cnt = 8'd1;
					m_state = PS_PAYLOAD;
				end
				PS_PAYLOAD: begin
					if (mode == `NX4_MODE_REG) begin
						txq.push_back(wr ? status : m_regs[idx]);
						if (wr)
							m_regs[idx] = data;
					end else if (mode == `NX4_MODE_FB && wr) begin
						cur_fb.we0 = m_regs[`NX4_REG_SYSCTL][`NX4_SYSCTL_BIT_FB0_WRITE];
						cur_fb.we1 = m_regs[`NX4_REG_SYSCTL][`NX4_SYSCTL_BIT_FB1_WRITE];
						cur_fb.addr = m_addr[`NX4_FB_ADDR_BITS-1:0];
						cur_fb.data = data;
					end else if (mode == `NX4_MODE_GAMMA && wr) begin
						if (!m_addr[0]) begin
							m_latch = data[3:0];	// even byte, high part
						end else begin
							cur_lut.we = 1'b1;
							cur_lut.addr = m_addr[8:1];
							cur_lut.data = {m_latch, data};
						end
					end
					if (len != 8'd0 && m_cnt == len) begin
						m_addr = m_addr + {{8{modulo[7]}}, modulo};	// end of run
						m_cnt = 8'd1;
					end else begin
						m_addr = m_addr + 16'd1;
						m_cnt = m_cnt + 8'd1;
					end
				end
				default: ;
			endcase
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus, driven 1 ns after the rising edge
	//////////////////////////////////////////////////////////////////////
	task automatic set_ready();
		if (ready_hold > 0) begin
			tx_ready = 1'b1;	// reply window, holder must drain
			ready_hold--;
		end else begin
			tx_ready = 1'($urandom);
		end
	endtask

	task automatic idle_cycle();
		@(posedge CLK_40);
		#1;
		rx_valid = 1'b0;
		rx.data = byte_t'($urandom);	// junk while invalid
		rx.start = 1'($urandom);
		cur_fb = '0;
		cur_lut = '0;
		set_ready();
	endtask

	task automatic drive_byte(input logic start, input byte_t data, input int gap,
		input logic hold);
		@(posedge CLK_40);
		#1;
		if (hold)
			ready_hold = 10;
		rx_valid = 1'b1;
		rx.data = data;
		rx.start = start;
		status = byte_t'($urandom);	// held through the gap
		cur_fb = '0;
		cur_lut = '0;
		model_byte(start, data);
		set_ready();
		repeat (gap) idle_cycle();
	endtask

	// id, address low, fb address high, then everything in pay_q
	task automatic send_message(input byte_t id, input byte_t lo, input byte_t hi);
		logic is_reg;
		int gap;
		is_reg = (id[`NX4_CMD_MODE_LSB +: 3] == `NX4_MODE_REG);
		gap = is_reg ? 6 + $urandom_range(0, 2) : 1 + $urandom_range(0, 2);
		drive_byte(1'b1, id, gap, is_reg);
		drive_byte(1'b0, lo, gap, is_reg);
		if (id[`NX4_CMD_MODE_LSB +: 3] == `NX4_MODE_FB)
			drive_byte(1'b0, hi, gap, is_reg);
		while (pay_q.size() > 0)
			drive_byte(1'b0, pay_q.pop_front(), gap, is_reg);
	endtask

	task automatic fill_payload(input int n);
		repeat (n) pay_q.push_back(byte_t'($urandom));
	endtask

	task automatic random_message();
		cmd_mode_t mode;
		unit_id_t unit;
		logic wr;
		case ($urandom_range(0, 2))
			0: mode = `NX4_MODE_REG;
			1: mode = `NX4_MODE_FB;
			default: mode = `NX4_MODE_GAMMA;
		endcase
		case ($urandom_range(0, 3))
			0: unit = m_regs[`NX4_REG_UNIT_ID][3:0];
			1: unit = `NX4_UNIT_ID_BROADCAST;
			default: unit = unit_id_t'($urandom);	// mostly foreign
		endcase
		wr = ($urandom_range(0, 3) != 0);
		fill_payload((mode == `NX4_MODE_REG) ? $urandom_range(0, 4) : $urandom_range(0, 8));
		send_message({unit, wr, mode}, byte_t'($urandom), byte_t'($urandom));
	endtask

	//////////////////////////////////////////////////////////////////////
	// monitor, samples at the falling edge
	//////////////////////////////////////////////////////////////////////
	always @(negedge CLK_40) begin
		if (!reset) begin
			check_value("fb_wr.we0", 128'(fb_wr.we0), 128'(s2_fb.we0));
			check_value("fb_wr.we1", 128'(fb_wr.we1), 128'(s2_fb.we1));
			check_value("lut_wr.we", 128'(lut_wr.we), 128'(s2_lut.we));
			if (s2_fb.we0 || s2_fb.we1) begin
				check_value("fb_wr.addr", 128'(fb_wr.addr), 128'(s2_fb.addr));
				check_value("fb_wr.data", 128'(fb_wr.data), 128'(s2_fb.data));
			end
			if (s2_lut.we) begin
				check_value("lut_wr.addr", 128'(lut_wr.addr), 128'(s2_lut.addr));
				check_value("lut_wr.data", 128'(lut_wr.data), 128'(s2_lut.data));
			end
			check_value("regs", 128'(regs), 128'(s2_regs));
			if (tx_valid && tx_ready) begin	// transfer on the next edge
				if (txq.size() == 0) begin
					errors++;
					$display("unexpected byte %0h on tx at %0t", tx_data, $time);
				end else begin
					check_value("tx_data", 128'(tx_data), 128'(txq.pop_front()));
				end
			end
		end
		s2_fb = s1_fb;
		s1_fb = cur_fb;
		s2_lut = s1_lut;
		s1_lut = cur_lut;
		s2_regs = s1_regs;
		s1_regs = m_regs;
	end

	initial begin
		int i;
		void'($urandom(32'h2244c2f2));
		errors = 0;
		checks = 0;
		ready_hold = 0;
		reset = 1'b1;
		rx = '0;
		rx_valid = 1'b0;
		status = '0;
		tx_ready = 1'b0;
		cur_fb = '0;
		cur_lut = '0;
		s1_fb = '0;
		s2_fb = '0;
		s1_lut = '0;
		s2_lut = '0;
		m_state = PS_IDLE;
		m_id = '0;
		m_addr = '0;
		m_cnt = 8'd1;
		m_latch = 4'h0;
		m_regs = '0;
		m_regs[`NX4_REG_SYSCTL] = `NX4_SYSCTL_RESET;
		s1_regs = m_regs;
		s2_regs = m_regs;
		boot = `NX4_BOOT_TEXT;
		for (i = 0; i < boot.len(); i++)
			txq.push_back(boot[i]);
		repeat (16) @(posedge CLK_40);
		#1;
		reset = 1'b0;
		while (txq.size() > 0)	// boot text with random tx_ready
			idle_cycle();

		pay_q.push_back(8'h05);
		send_message(8'hF8, 8'h01, 8'h00);	// broadcast, unit id = 5
		fill_payload(1);
		send_message(8'h50, 8'h01, 8'h00);	// read it back
		pay_q.push_back(8'h03);
		send_message(8'h58, 8'h00, 8'h00);	// sysctl, both framebuffers
		fill_payload(2);
		send_message(8'h38, 8'h00, 8'h00);	// foreign reg write
		fill_payload(3);
		send_message(8'h39, 8'h00, 8'h00);	// foreign fb write
		fill_payload(4);
		send_message(8'h59, 8'h10, 8'h02);
		drive_byte(1'b1, 8'h59, 1, 1'b0);	// lone start, restarted below
		fill_payload(2);
		send_message(8'h3C, 8'h00, 8'h00);
		fill_payload(6);
		send_message(8'h5C, 8'h00, 8'h00);	// gamma pairs from an even address
		fill_payload(4);
		send_message(8'hFC, 8'h07, 8'h00);	// odd start reuses the latch
		pay_q.push_back(8'h03);
		pay_q.push_back(8'hFE);
		send_message(8'h58, 8'h08, 8'h00);	// autoinc len 3, modulo -2
		fill_payload(10);
		send_message(8'h59, 8'h00, 8'h01);
		fill_payload(2);
		send_message(8'h50, 8'h08, 8'h00);
		repeat (N_RAND) random_message();
		repeat (20) idle_cycle();	// flush pipeline and holder

		if (txq.size() != 0)
			$display("%0d expected tx bytes never arrived", txq.size());
		$display("checks %0d, errors %0d, missing tx bytes %0d", checks, errors, txq.size());
		if (errors == 0 && txq.size() == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: tx_sequencer.sv
`timescale 1ns/1ps
`include "nx4_cmd_config.svh"

module tx_sequencer (
	input logic CLK_40,
	input logic reset,
	input nx4_cmd_pkg::byte_t reply,
	input logic reply_valid,
	input logic rx_valid,
	input logic tx_ready,
	output nx4_cmd_pkg::byte_t tx_data,
	output logic tx_valid
);
	import nx4_cmd_pkg::*;

	typedef logic [$clog2(`NX4_BOOT_LEN+1)-1:0] boot_cnt_t;
	typedef logic [$clog2(`NX4_BOOT_LEN)-1:0] boot_idx_t;

	localparam boot_cnt_t BOOT_LEN = boot_cnt_t'(`NX4_BOOT_LEN);
	localparam logic [8*`NX4_BOOT_LEN-1:0] BOOT_ROM = `NX4_BOOT_TEXT;

	byte_t hold_data;	// single-entry holder
	logic hold_full;
	boot_cnt_t boot_cnt;	// chars still to send, counts down
	boot_idx_t boot_idx;
	logic reply_load, boot_load;

	assign boot_idx = boot_idx_t'(boot_cnt - 1'b1);	// cnt 16 picks the top byte
	// a reply fits if the holder is empty or draining this cycle, else it is lost
	assign reply_load = reply_valid && (!hold_full || tx_ready);
	// boot text only fills idle gaps
	assign boot_load = !hold_full && !reply_valid && !rx_valid && (boot_cnt != '0);

	always_ff @(posedge CLK_40 or posedge reset) begin
		if (reset) begin
			hold_full <= 1'b0;
			boot_cnt <= BOOT_LEN;
		end else if (reply_load) begin
			hold_full <= 1'b1;
		end else if (boot_load) begin
			hold_full <= 1'b1;
			boot_cnt <= boot_cnt - 1'b1;
		end else if (tx_ready) begin
			hold_full <= 1'b0;	// transfer done
		end
	end

	always_ff @(posedge CLK_40) begin
		if (reply_load)
			hold_data <= reply;
		else if (boot_load)
			hold_data <= BOOT_ROM[boot_idx*8 +: 8];
	end

	assign tx_data = hold_data;	// stable until the transfer
	assign tx_valid = hold_full;

endmodule
